// ==== Makefile ====
TOP := tb_fb_line

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f source/*.sv source/*.svh verification/*.sv verification/*.svh
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP)

# pass only if the testbench printed its pass line
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== source/bram_sdp.sv ====
/* simple dual-port RAM on one clock, contents undefined at power-up
   read is registered, a write is seen by reads from the next cycle on */
`timescale 1ns/1ps

module bram_sdp #(
    parameter int WIDTH = 4,      // bits per word
    parameter int DEPTH = 19200   // words
) (
    input  wire logic clk_pix,
    input  wire logic we,
    input  wire logic [$clog2(DEPTH)-1:0] addr_write,
    input  wire logic [WIDTH-1:0] data_in,
    input  wire logic [$clog2(DEPTH)-1:0] addr_read,
    output      logic [WIDTH-1:0] data_out    // one cycle after addr_read
);

    logic [WIDTH-1:0] memory [DEPTH];

    always_ff @(posedge clk_pix) begin
        if (we) begin
            memory[addr_write] <= data_in;
        end
    end

    // read before write on a shared address
    always_ff @(posedge clk_pix) begin
        data_out <= memory[addr_read];
    end

endmodule

// ==== source/display_timings.sv ====
/* 640x480 counters over the full 800x525 frame, syncs active low
   sx and sy are zero in the first cycle after reset is released */
`timescale 1ns/1ps
`include "fb_settings.svh"

module display_timings import fb_pkg::*; (
    input  wire logic clk_pix,  // 25 MHz
    input  wire logic rst_n,    // sync, active low
    output      coord_t sx,     // horizontal position
    output      coord_t sy,     // vertical position
    output      logic hsync,
    output      logic vsync,
    output      logic de        // visible area enable
);

    localparam coord_t H_TOTAL  = coord_t'(`FB_H_TOTAL);
    localparam coord_t H_LAST   = coord_t'(`FB_H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(`FB_V_TOTAL - 1);
    localparam coord_t H_RES    = coord_t'(`FB_H_RES);
    localparam coord_t V_RES    = coord_t'(`FB_V_RES);
    localparam coord_t HS_START = coord_t'(`FB_HS_START);
    localparam coord_t HS_END   = coord_t'(`FB_HS_END);
    localparam coord_t VS_START = coord_t'(`FB_VS_START);
    localparam coord_t VS_END   = coord_t'(`FB_VS_END);

    // position counters
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_LAST) begin  // end of line
            sx <= '0;
            sy <= (sy == V_LAST) ? '0 : sy + 1'b1;  // wrap at end of frame
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync and enable decode
    always_comb begin
        hsync = ~((sx >= HS_START) && (sx < HS_END));  // low during pulse
        vsync = ~((sy >= VS_START) && (sy < VS_END));
        de    = (sx < H_RES) && (sy < V_RES);
    end

    // line length must stay at 800 cycles
    a_sx_range: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sx < H_TOTAL);

endmodule

// ==== source/draw_cmd_regs.sv ====
/* Wishbone classic slave for line commands, ack one cycle after request
   no wait states and no error or retry; a start while busy is dropped */
`timescale 1ns/1ps

module draw_cmd_regs import fb_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic wb_cyc,
    input  wire logic wb_stb,
    input  wire logic wb_we,
    input  wire wb_addr_t wb_adr,
    input  wire wb_data_t wb_dat_w,
    output      wb_data_t wb_dat_r,
    output      logic wb_ack,
    input  wire logic busy,        // from line drawer
    output      coord_t cmd_row,
    output      coord_t cmd_x0,
    output      coord_t cmd_x1,
    output      colour_t cmd_colour,
    output      logic cmd_start    // single cycle
);

    localparam wb_addr_t ADR_ROW    = 3'd0;
    localparam wb_addr_t ADR_X0     = 3'd1;
    localparam wb_addr_t ADR_X1     = 3'd2;
    localparam wb_addr_t ADR_COLOUR = 3'd3;
    localparam wb_addr_t ADR_START  = 3'd4;
    localparam wb_addr_t ADR_STATUS = 3'd5;

    logic req;       // new request this cycle
    wb_data_t rd_mux;

    assign req = wb_cyc && wb_stb && !wb_ack;  // ignore the cycle ack is high

    always_comb begin
        case (wb_adr)
            ADR_ROW:    rd_mux = {6'b0, cmd_row};
            ADR_X0:     rd_mux = {6'b0, cmd_x0};
            ADR_X1:     rd_mux = {6'b0, cmd_x1};
            ADR_COLOUR: rd_mux = {12'b0, cmd_colour};
            ADR_STATUS: rd_mux = {15'b0, busy};
            default:    rd_mux = '0;  // start reads as zero
        endcase
    end

    // ack, command registers and start pulse
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            cmd_start  <= 1'b0;
            cmd_row    <= '0;
            cmd_x0     <= '0;
            cmd_x1     <= '0;
            cmd_colour <= '0;
        end else begin
            wb_ack    <= req;
            cmd_start <= req && wb_we && (wb_adr == ADR_START) && !busy;
            if (req && wb_we) begin
                case (wb_adr)
                    ADR_ROW:    cmd_row    <= wb_dat_w[9:0];
                    ADR_X0:     cmd_x0     <= wb_dat_w[9:0];
                    ADR_X1:     cmd_x1     <= wb_dat_w[9:0];
                    ADR_COLOUR: cmd_colour <= wb_dat_w[3:0];
                    default:    ;  // start handled above, status read only
                endcase
            end
        end
    end

    // read data held through the ack cycle
    always_ff @(posedge clk_pix) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_mux;
        end
    end

    a_ack_single: assert property (@(posedge clk_pix) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

    // drawer must never see a start while it works
    a_start_idle: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !(cmd_start && busy));

endmodule

// ==== source/fb_line_top.sv ====
/* line drawing framebuffer with Wishbone command port and 640x480 VGA out
   clk_pix must be a 25 MHz pixel clock, no PLL inside */
`timescale 1ns/1ps
`include "fb_settings.svh"

module fb_line_top import fb_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic wb_cyc,
    input  wire logic wb_stb,
    input  wire logic wb_we,
    input  wire wb_addr_t wb_adr,
    input  wire wb_data_t wb_dat_w,
    output      wb_data_t wb_dat_r,
    output      logic wb_ack,
    output      logic vga_hsync,
    output      logic vga_vsync,
    output      logic vga_de,
    output      colour_t vga_r,
    output      colour_t vga_g,
    output      colour_t vga_b
);

    coord_t sx, sy;
    logic hsync, vsync, de;
    logic fb_we;
    fb_addr_t fb_addr_write, fb_addr_read;
    colour_t fb_colr_write, fb_colr_read;
    coord_t cmd_row, cmd_x0, cmd_x1;
    colour_t cmd_colour;
    logic cmd_start, busy;

    display_timings i_timings (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de
    );

    // framebuffer, one colour_t per pixel
    bram_sdp #(
        .WIDTH($bits(colour_t)),
        .DEPTH(`FB_PIXELS)
    ) i_fb (
        .clk_pix,
        .we(fb_we),
        .addr_write(fb_addr_write),
        .data_in(fb_colr_write),
        .addr_read(fb_addr_read),
        .data_out(fb_colr_read)
    );

    draw_cmd_regs i_regs (
        .clk_pix, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_dat_r, .wb_ack, .busy, .cmd_row, .cmd_x0, .cmd_x1, .cmd_colour, .cmd_start
    );

    line_drawer i_drawer (
        .clk_pix, .rst_n, .sy, .cmd_row, .cmd_x0, .cmd_x1, .cmd_colour, .cmd_start,
        .busy, .fb_we, .fb_addr_write, .fb_colr_write
    );

    pixel_out i_pixel (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .fb_addr_read, .fb_colr_read,
        .vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
    );

endmodule

// ==== source/fb_pkg.sv ====
/* shared types for the line drawing subsystem
   widths here must agree with fb_settings.svh */
package fb_pkg;

    typedef logic [9:0]  coord_t;    // screen coordinate, up to 1023
    typedef logic [14:0] fb_addr_t;  // 160x120 needs 15 bits
    typedef logic [3:0]  colour_t;   // grey level
    typedef logic [2:0]  wb_addr_t;  // word address
    typedef logic [15:0] wb_data_t;

    // line drawer FSM
    typedef enum logic [1:0] {
        IDLE, WAIT_BLANK, DRAW, DONE
    } draw_state_t;

endpackage

// ==== source/fb_settings.svh ====
/* display timing is fixed 640x480 at 60 Hz on a 25 MHz pixel clock
   framebuffer is 160x120 and sits unscaled at the top-left of the screen */
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// visible area
`define FB_H_RES     640
`define FB_V_RES     480
// full frame with blanking
`define FB_H_TOTAL   800
`define FB_V_TOTAL   525
// sync pulses, both active low
`define FB_HS_START  656
`define FB_HS_END    752
`define FB_VS_START  490
`define FB_VS_END    492
// framebuffer geometry
`define FB_WIDTH     160
`define FB_HEIGHT    120
`define FB_PIXELS    (`FB_WIDTH * `FB_HEIGHT)

`endif

// ==== source/line_drawer.sv ====
/* draws one horizontal span per command, one pixel per cycle in vertical blanking
   out-of-range rows and columns clamp to the last framebuffer row and column */
`timescale 1ns/1ps
`include "fb_settings.svh"

module line_drawer import fb_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire coord_t sy,          // from display timings
    input  wire coord_t cmd_row,
    input  wire coord_t cmd_x0,
    input  wire coord_t cmd_x1,
    input  wire colour_t cmd_colour,
    input  wire logic cmd_start,
    output      logic busy,
    output      logic fb_we,
    output      fb_addr_t fb_addr_write,
    output      colour_t fb_colr_write
);

    localparam coord_t ROW_MAX = coord_t'(`FB_HEIGHT - 1);
    localparam coord_t COL_MAX = coord_t'(`FB_WIDTH - 1);
    localparam coord_t V_RES   = coord_t'(`FB_V_RES);

    draw_state_t state;
    coord_t row_c, xa_c, xb_c;  // clamped command fields
    coord_t x_lo, x_hi;         // ordered end columns
    coord_t x_cur, x_end;
    logic in_blank;

    always_comb begin
        row_c = (cmd_row > ROW_MAX) ? ROW_MAX : cmd_row;
        xa_c  = (cmd_x0 > COL_MAX) ? COL_MAX : cmd_x0;
        xb_c  = (cmd_x1 > COL_MAX) ? COL_MAX : cmd_x1;
        x_lo  = (xa_c < xb_c) ? xa_c : xb_c;
        x_hi  = (xa_c < xb_c) ? xb_c : xa_c;
    end

    assign in_blank = (sy >= V_RES);             // lines 480 to 524
    assign fb_we    = (state == DRAW) && in_blank;
    assign busy     = (state != IDLE);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:       if (cmd_start) state <= WAIT_BLANK;
                WAIT_BLANK: if (in_blank) state <= DRAW;
                DRAW: begin
                    if (!in_blank) state <= WAIT_BLANK;   // pause until next frame
                    else if (x_cur == x_end) state <= DONE;  // last pixel written
                end
                DONE:       state <= IDLE;  // holds busy until the write lands
                default:    state <= IDLE;
            endcase
        end
    end

    // span datapath latched on start and stepped per written pixel
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && cmd_start) begin
            x_cur         <= x_lo;
            x_end         <= x_hi;
            fb_addr_write <= fb_addr_t'(row_c * `FB_WIDTH + x_lo);  // row major
            fb_colr_write <= cmd_colour;
        end else if (fb_we && x_cur != x_end) begin
            x_cur         <= x_cur + 1'b1;
            fb_addr_write <= fb_addr_write + 1'b1;
        end
    end

    // writes only in blanking, in column order and inside the framebuffer
    a_we_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        fb_we |-> (sy >= V_RES) && (x_cur <= x_end) &&
                  (fb_addr_write < fb_addr_t'(`FB_PIXELS)));

endmodule

// ==== source/pixel_out.sv ====
/* VGA output stage, two cycles from timing counters to pins
   framebuffer shown unscaled at top-left, grey on all channels, black elsewhere */
`timescale 1ns/1ps
`include "fb_settings.svh"

module pixel_out import fb_pkg::*; (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire coord_t sx,
    input  wire coord_t sy,
    input  wire logic hsync,
    input  wire logic vsync,
    input  wire logic de,
    output      fb_addr_t fb_addr_read,
    input  wire colour_t fb_colr_read,   // one cycle after fb_addr_read
    output      logic vga_hsync,
    output      logic vga_vsync,
    output      logic vga_de,
    output      colour_t vga_r,
    output      colour_t vga_g,
    output      colour_t vga_b
);

    localparam coord_t FB_W = coord_t'(`FB_WIDTH);
    localparam coord_t FB_H = coord_t'(`FB_HEIGHT);

    logic fb_win;                          // position inside framebuffer
    logic win_d, hsync_d, vsync_d, de_d;   // aligned with RAM read data

    // address straight from position, no running counter to drift
    always_comb begin
        fb_win       = (sx < FB_W) && (sy < FB_H);
        fb_addr_read = fb_win ? fb_addr_t'(sy * `FB_WIDTH + sx) : '0;
    end

    // stage 1 matches the RAM read latency
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            win_d   <= 1'b0;
            hsync_d <= 1'b1;  // syncs idle high
            vsync_d <= 1'b1;
            de_d    <= 1'b0;
        end else begin
            win_d   <= fb_win;
            hsync_d <= hsync;
            vsync_d <= vsync;
            de_d    <= de;
        end
    end

    // stage 2, output registers
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_de    <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_de    <= de_d;
            vga_r     <= win_d ? fb_colr_read : '0;  // grey level
            vga_g     <= win_d ? fb_colr_read : '0;
            vga_b     <= win_d ? fb_colr_read : '0;
        end
    end

endmodule

// ==== sources.f ====
+incdir+source
+incdir+verification
source/fb_pkg.sv
source/display_timings.sv
source/bram_sdp.sv
source/draw_cmd_regs.sv
source/line_drawer.sv
source/pixel_out.sv
source/fb_line_top.sv
verification/tb_fb_line.sv

// ==== verification/tb_fb_model.svh ====
/* framebuffer reference model and compare tasks, included inside the testbench module
   assumes the DUT framebuffer RAM starts at zero, as Verilator does by default */
`ifndef TB_FB_MODEL_SVH
`define TB_FB_MODEL_SVH

colour_t fb_model [`FB_PIXELS];  // row major, like the DUT

// horizontal span, ends in any order, out-of-range values clamp to the last row or column
task automatic draw_line(input coord_t row, input coord_t x0, input coord_t x1,
                         input colour_t colour);
    int r;
    int a;
    int b;
    int lo;
    int hi;
    r = int'(row);
    a = int'(x0);
    b = int'(x1);
    if (r >= `FB_HEIGHT) r = `FB_HEIGHT - 1;
    if (a >= `FB_WIDTH) a = `FB_WIDTH - 1;
    if (b >= `FB_WIDTH) b = `FB_WIDTH - 1;
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    for (int x = lo; x <= hi; x++) begin
        fb_model[r * `FB_WIDTH + x] = colour;  // later lines win
    end
endtask

// what the screen should show at a visible position
function automatic colour_t expected_pixel(input int row, input int col);
    if (row >= 0 && row < `FB_HEIGHT && col < `FB_WIDTH)
        return fb_model[row * `FB_WIDTH + col];
    return '0;  // black outside the window
endfunction

task automatic check_colour(input string name, input colour_t exp, input colour_t act);
    if (act !== exp) begin
        value_errors++;
        $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_wb_data(input string name, input wb_data_t exp, input wb_data_t act);
    if (act !== exp) begin
        value_errors++;
        $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        value_errors++;
        $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
    end
endtask

// cycle and line counts from frame capture
task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        value_errors++;
        $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

`endif

// ==== verification/tb_fb_line.sv ====
/* testbench for fb_line_top, random line commands from a fixed seed
   checks register readback, captured VGA frames against a model, and sync timing */
`timescale 1ns/1ps
`include "fb_settings.svh"

module tb_fb_line import fb_pkg::*; ();

    localparam int CLK_HALF       = 50;  // 100 ns period
    localparam int FRAME_CYCLES   = `FB_H_TOTAL * `FB_V_TOTAL;
    localparam int TIMEOUT_CYCLES = 12 * FRAME_CYCLES;  // 8 commands, 2 captures, margin
    localparam int ACK_LIMIT      = 16;
    localparam int POLL_LIMIT     = FRAME_CYCLES;  // status reads per command
    localparam int unsigned SEED  = 32'h3265_6c85;
    localparam wb_addr_t ADR_ROW    = 3'd0;
    localparam wb_addr_t ADR_X0     = 3'd1;
    localparam wb_addr_t ADR_X1     = 3'd2;
    localparam wb_addr_t ADR_COLOUR = 3'd3;
    localparam wb_addr_t ADR_START  = 3'd4;
    localparam wb_addr_t ADR_STATUS = 3'd5;

    logic clk_pix;
    logic rst_n;
    logic wb_cyc, wb_stb, wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w, wb_dat_r;
    logic wb_ack;
    logic vga_hsync, vga_vsync, vga_de;
    colour_t vga_r, vga_g, vga_b;
    int value_errors = 0;  // wrong values
    int other_errors = 0;  // missing ack, stuck busy
    int cycle_count = 0;

    `include "tb_fb_model.svh"

    fb_line_top i_dut (
        .clk_pix, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .vga_hsync, .vga_vsync, .vga_de, .vga_r, .vga_g, .vga_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #CLK_HALF clk_pix = ~clk_pix;
    end

    always @(posedge clk_pix) cycle_count <= cycle_count + 1;

    // hard stop if anything hangs
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, test sequence did not finish", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // one classic bus cycle driven on the falling edge
    task automatic wb_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                            output wb_data_t rdata);
        int waited;
        @(negedge clk_pix);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        @(negedge clk_pix);
        waited = 1;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(negedge clk_pix);
            waited++;
        end
        rdata = wb_dat_r;  // valid while ack high
        if (!wb_ack) begin
            other_errors++;
            $display("no ack from the Wishbone slave at address %0d", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t ignored;
        wb_cycle(1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        wb_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic write_cmd(input coord_t row, input coord_t x0, input coord_t x1,
                             input colour_t colour);
        wb_write(ADR_ROW, wb_data_t'(row));
        wb_write(ADR_X0, wb_data_t'(x0));
        wb_write(ADR_X1, wb_data_t'(x1));
        wb_write(ADR_COLOUR, wb_data_t'(colour));
    endtask

    // poll status until busy drops
    task automatic wait_idle();
        wb_data_t status;
        int polls;
        polls = 0;
        wb_read(ADR_STATUS, status);
        while (status[0] && polls < POLL_LIMIT) begin
            wb_read(ADR_STATUS, status);
            polls++;
        end
        if (status[0]) begin
            other_errors++;
            $display("busy bit never cleared after a line command");
        end
    endtask

    task automatic draw_and_wait(input coord_t row, input coord_t x0, input coord_t x1,
                                 input colour_t colour);
        write_cmd(row, x0, x1, colour);
        wb_write(ADR_START, wb_data_t'($urandom));  // any value starts
        draw_line(row, x0, x1, colour);
        wait_idle();
    endtask

    // one frame from vsync fall to vsync fall
    task automatic capture_frame();
        int row;
        int col;
        int hs_low;
        int vs_low;
        logic vs_prev;
        logic de_prev;
        colour_t exp;
        @(negedge clk_pix);
        vs_prev = vga_vsync;
        @(negedge clk_pix);
        while (!(vs_prev && !vga_vsync)) begin
            vs_prev = vga_vsync;
            @(negedge clk_pix);
        end
        row     = -1;  // first de rise is row 0
        col     = 0;
        hs_low  = 0;
        vs_low  = 0;
        de_prev = 1'b0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            if (vga_de && !de_prev) begin
                row++;
                col = 0;
            end
            if (vga_de) begin
                exp = expected_pixel(row, col);
                check_colour("vga_r", exp, vga_r);
                check_colour("vga_g", exp, vga_g);
                check_colour("vga_b", exp, vga_b);
                col++;
            end else if (de_prev) begin
                check_count("vga_de run length", `FB_H_RES, col);
            end
            de_prev = vga_de;
            @(negedge clk_pix);
        end
        check_count("vga_de lines", `FB_V_RES, row + 1);
        check_count("vga_hsync low cycles", 96 * `FB_V_TOTAL, hs_low);  // 96 per line
        check_count("vga_vsync low cycles", 2 * `FB_H_TOTAL, vs_low);   // 2 lines
    endtask

    initial begin
        wb_data_t rd;
        wb_data_t dat;
        wb_data_t mask;
        coord_t row, x0, x1;
        colour_t colour;
        int unsigned seed_val;
        int b_addr;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        foreach (fb_model[i]) fb_model[i] = '0;
        seed_val = $urandom(SEED);
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        // idle levels while still in reset
        check_flag("wb_ack", 1'b0, wb_ack);
        check_flag("vga_hsync", 1'b1, vga_hsync);
        check_flag("vga_vsync", 1'b1, vga_vsync);
        check_flag("vga_de", 1'b0, vga_de);
        check_colour("vga_r", '0, vga_r);
        check_colour("vga_g", '0, vga_g);
        check_colour("vga_b", '0, vga_b);
        rst_n = 1'b1;

        // nothing drawn yet so the screen is black
        wb_read(ADR_STATUS, rd);
        check_wb_data("status", 16'h0000, rd);
        capture_frame();

        // readback masked to register widths
        for (int a = 0; a < 4; a++) begin
            dat  = wb_data_t'($urandom);
            mask = (a == 3) ? 16'h000f : 16'h03ff;
            wb_write(wb_addr_t'(a), dat);
            wb_read(wb_addr_t'(a), rd);
            check_wb_data("wb_dat_r", dat & mask, rd);
        end
        wb_read(3'd6, rd);
        check_wb_data("unused address 6", 16'h0000, rd);
        wb_read(3'd7, rd);
        check_wb_data("unused address 7", 16'h0000, rd);

        // six random lines inside the framebuffer with overlaps allowed
        repeat (6) begin
            row    = coord_t'($urandom_range(`FB_HEIGHT - 1, 0));
            x0     = coord_t'($urandom_range(`FB_WIDTH - 1, 0));
            x1     = coord_t'($urandom_range(`FB_WIDTH - 1, 0));
            colour = colour_t'($urandom);
            draw_and_wait(row, x0, x1, colour);
        end

        // x1 left of x0
        row = coord_t'($urandom_range(`FB_HEIGHT - 1, 0));
        x0  = coord_t'($urandom_range(`FB_WIDTH - 1, 80));
        x1  = coord_t'($urandom_range(79, 0));
        draw_and_wait(row, x0, x1, colour_t'($urandom));

        // long clamped line with a second start while busy
        row    = coord_t'($urandom_range(1023, `FB_HEIGHT));
        x0     = coord_t'($urandom_range(20, 0));
        x1     = coord_t'($urandom_range(1023, `FB_WIDTH));
        colour = colour_t'($urandom);
        write_cmd(row, x0, x1, colour);
        wb_write(ADR_START, 16'h0001);
        draw_line(row, x0, x1, colour);
        wb_read(ADR_STATUS, rd);
        check_wb_data("status while drawing", 16'h0001, rd);
        row    = coord_t'($urandom_range(`FB_HEIGHT - 1, 0));
        x0     = coord_t'($urandom_range(`FB_WIDTH - 1, 0));
        b_addr = int'(row) * `FB_WIDTH + int'(x0);
        colour = fb_model[b_addr] ^ 4'hf;  // differs from what the model holds there
        write_cmd(row, x0, x0, colour);
        wb_read(ADR_STATUS, rd);
        check_wb_data("status before dropped start", 16'h0001, rd);
        wb_write(ADR_START, 16'h0001);  // acked but ignored
        // start was just written with a nonzero value
        wb_read(ADR_START, rd);
        check_wb_data("start readback", 16'h0000, rd);
        wait_idle();

        capture_frame();

        $display("errors: %0d value mismatches, %0d other failures", value_errors,
                 other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
